/* design/lcd_timing_pkg.sv */
package lcd_timing_pkg;

  ////////////////////////////////////////
  // Clock and delay lengths
  ////////////////////////////////////////

  localparam int unsigned CLK_FREQ_HZ = 1_000_000;

  // Nanoseconds to clock cycles, rounded up, never below one cycle
  function automatic int unsigned ns_to_cyc(input longint unsigned ns);
    longint unsigned cyc;
    cyc = (ns * CLK_FREQ_HZ + 64'd999_999_999) / 64'd1_000_000_000;
    return (cyc == 0) ? 32'd1 : 32'(cyc);
  endfunction

  localparam int unsigned T_40NS_CYC  = ns_to_cyc(40);
  localparam int unsigned T_250NS_CYC = ns_to_cyc(250);
  localparam int unsigned T_42US_CYC  = ns_to_cyc(42_000);
  localparam int unsigned T_60US_CYC  = ns_to_cyc(60_000);
  localparam int unsigned T_100US_CYC = ns_to_cyc(100_000);
  localparam int unsigned T_5MS_CYC   = ns_to_cyc(5_000_000);
  localparam int unsigned T_100MS_CYC = ns_to_cyc(100_000_000);

  typedef logic [16:0] delay_cnt_t;  // Wide enough for the 100 ms wait

  // Settle time after a bus write
  typedef enum logic [2:0] {
    DLY_42US,
    DLY_84US,
    DLY_60US,
    DLY_100US,
    DLY_5MS,
    DLY_100MS
  } lcd_delay_e;

endpackage

/* design/lcd_cmd_pkg.sv */
package lcd_cmd_pkg;

  ////////////////////////////////////////
  // HD44780 command bytes
  ////////////////////////////////////////

  localparam logic [7:0] CMD_FUNC_WAKE = 8'h30;  // Function set, wake-up form
  localparam logic [7:0] CMD_SETUP     = 8'h38;  // 8-bit bus, 2 lines, 5x7 font
  localparam logic [7:0] CMD_DISP_OFF  = 8'h08;
  localparam logic [7:0] CMD_CLEAR     = 8'h01;
  localparam logic [7:0] CMD_ENTRY_N   = 8'h06;  // Cursor moves, display still
  localparam logic [7:0] CMD_DISP_ON   = 8'h0C;

  // Command steps of the power-on list, the leading wait excluded
  localparam int unsigned INIT_STEPS = 8;

  ////////////////////////////////////////
  // Host side
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_IDLE        = 2'd0,
    OP_WRITE_CHAR  = 2'd1,
    OP_REINIT      = 2'd2,
    OP_WRITE_INSTR = 2'd3
  } lcd_op_e;

  typedef struct packed {
    lcd_op_e    op;
    logic [7:0] data;
  } lcd_host_req_t;

  ////////////////////////////////////////
  // Transfers and pins
  ////////////////////////////////////////

  // One write on the LCD bus, or a plain wait when strobe is low
  typedef struct packed {
    logic                      strobe;
    logic                      rs;
    logic [7:0]                data;
    lcd_timing_pkg::lcd_delay_e post_dly;
  } lcd_xfer_t;

  typedef struct packed {
    logic       rs;
    logic       e;
    logic [7:0] data;
  } lcd_bus_t;

endpackage

/* design/lcd_delay_timer.sv */
`timescale 1ns/1ps

module lcd_delay_timer (
  input  logic                       clk_i,
  input  logic                       flag_rst,
  input  logic                       start_i,
  input  lcd_timing_pkg::delay_cnt_t cycles_i,
  output logic                       done_o
);

  import lcd_timing_pkg::*;

  delay_cnt_t cnt;
  logic       running;

  // Expiry is seen in the N-th cycle after the start pulse
  assign done_o = running && (cnt == '0);

  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      cnt     <= '0;
      running <= 1'b0;
    end else if (start_i) begin
      cnt     <= cycles_i - 1'b1;  // Reload wins over expiry
      running <= 1'b1;
    end else if (running) begin
      if (cnt == '0) begin
        running <= 1'b0;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // A new delay may only be loaded once the previous one is over
  assert property (@(posedge clk_i) disable iff (flag_rst)
    start_i |-> (!running || done_o))
    else $error("delay timer restarted while a count was running");

  // Zero would never expire
  assert property (@(posedge clk_i) disable iff (flag_rst)
    start_i |-> (cycles_i != '0))
    else $error("delay timer loaded with zero cycles");

endmodule

/* design/lcd_bus_cycle.sv */
`timescale 1ns/1ps

module lcd_bus_cycle (
  input  logic                   clk_i,
  input  logic                   flag_rst,
  input  logic                   req_i,
  input  lcd_cmd_pkg::lcd_xfer_t xfer_i,
  output logic                   ack_o,
  output lcd_cmd_pkg::lcd_bus_t  lcd_o
);

  import lcd_timing_pkg::*;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_E_HI,    // E up, waiting before data
    PH_DATA,    // Data on the bus, waiting for E to drop
    PH_SETTLE,  // Post-write delay
    PH_ACK
  } phase_e;

  phase_e     phase;
  logic       tmr_start;
  logic       tmr_done;
  delay_cnt_t tmr_cycles;

  function automatic delay_cnt_t post_cycles(input lcd_delay_e dly);
    case (dly)
      DLY_42US:  return delay_cnt_t'(T_42US_CYC);
      DLY_84US:  return delay_cnt_t'(2 * T_42US_CYC);
      DLY_60US:  return delay_cnt_t'(T_60US_CYC);
      DLY_100US: return delay_cnt_t'(T_100US_CYC);
      DLY_5MS:   return delay_cnt_t'(T_5MS_CYC);
      default:   return delay_cnt_t'(T_100MS_CYC);
    endcase
  endfunction

  ////////////////////////////////////////
  // Timer loads per phase
  ////////////////////////////////////////

  always_comb begin
    tmr_start  = 1'b0;
    tmr_cycles = post_cycles(xfer_i.post_dly);
    case (phase)
      PH_IDLE: begin
        tmr_start = req_i;
        if (xfer_i.strobe) begin
          tmr_cycles = delay_cnt_t'(T_40NS_CYC);
        end
      end
      PH_E_HI: begin
        tmr_start  = tmr_done;
        tmr_cycles = delay_cnt_t'(T_250NS_CYC);
      end
      PH_DATA: tmr_start = tmr_done;  // Post delay follows E falling
      default: tmr_start = 1'b0;
    endcase
  end

  lcd_delay_timer u_timer (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .start_i  (tmr_start),
    .cycles_i (tmr_cycles),
    .done_o   (tmr_done)
  );

  ////////////////////////////////////////
  // Phase machine and pins
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      phase <= PH_IDLE;
      ack_o <= 1'b0;
      lcd_o <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (req_i && xfer_i.strobe) begin
            lcd_o.e  <= 1'b1;
            lcd_o.rs <= xfer_i.rs;
            phase    <= PH_E_HI;
          end else if (req_i) begin
            phase <= PH_SETTLE;  // Wait-only transfer, E stays low
          end
        end
        PH_E_HI: begin
          if (tmr_done) begin
            lcd_o.data <= xfer_i.data;
            phase      <= PH_DATA;
          end
        end
        PH_DATA: begin
          if (tmr_done) begin
            lcd_o.e <= 1'b0;
            phase   <= PH_SETTLE;
          end
        end
        PH_SETTLE: begin
          if (tmr_done) begin
            ack_o <= 1'b1;
            phase <= PH_ACK;
          end
        end
        default: begin
          if (!req_i) begin
            ack_o <= 1'b0;
            phase <= PH_IDLE;
          end
        end
      endcase
    end
  end

  // Source must hold req until the write is acknowledged
  assert property (@(posedge clk_i) disable iff (flag_rst)
    (req_i && !ack_o) |=> req_i)
    else $error("bus req dropped before ack");

  assert property (@(posedge clk_i) disable iff (flag_rst)
    ack_o |-> !lcd_o.e)
    else $error("E still high at ack");

endmodule

/* design/lcd_init_seq.sv */
`timescale 1ns/1ps

module lcd_init_seq (
  input  logic                   clk_i,
  input  logic                   flag_rst,
  input  logic                   start_i,
  output logic                   busy_o,
  output logic                   req_o,
  input  logic                   ack_i,
  output lcd_cmd_pkg::lcd_xfer_t xfer_o
);

  import lcd_timing_pkg::*;
  import lcd_cmd_pkg::*;

  // Step 0 is the power-on wait and steps 1 to INIT_STEPS send commands
  logic [3:0] step;

  ////////////////////////////////////////
  // Power-on command list
  ////////////////////////////////////////

  function automatic lcd_xfer_t step_xfer(input logic [3:0] idx);
    lcd_xfer_t x;
    x.strobe = 1'b1;
    x.rs     = 1'b0;  // All init steps are instructions
    case (idx)
      4'd0: begin
        x.strobe   = 1'b0;
        x.data     = 8'h00;
        x.post_dly = DLY_100MS;
      end
      4'd1: begin
        x.data     = CMD_FUNC_WAKE;
        x.post_dly = DLY_5MS;
      end
      4'd2, 4'd3: begin
        x.data     = CMD_FUNC_WAKE;
        x.post_dly = DLY_100US;
      end
      4'd4: begin
        x.data     = CMD_SETUP;
        x.post_dly = DLY_100US;
      end
      4'd5: begin
        x.data     = CMD_DISP_OFF;
        x.post_dly = DLY_60US;
      end
      4'd6: begin
        x.data     = CMD_CLEAR;
        x.post_dly = DLY_5MS;
      end
      4'd7: begin
        x.data     = CMD_ENTRY_N;
        x.post_dly = DLY_60US;
      end
      default: begin
        x.data     = CMD_DISP_ON;
        x.post_dly = DLY_60US;
      end
    endcase
    return x;
  endfunction

  assign xfer_o = step_xfer(step);  // Stable while req_o is high

  ////////////////////////////////////////
  // Step walk
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      step   <= '0;
      busy_o <= 1'b1;  // Init runs on its own after reset
      req_o  <= 1'b0;
    end else if (start_i) begin
      step   <= '0;
      busy_o <= 1'b1;
    end else if (busy_o) begin
      if (req_o && ack_i) begin
        req_o <= 1'b0;
        step  <= step + 1'b1;
      end else if (!req_o && !ack_i) begin
        if (step > 4'(INIT_STEPS)) begin
          busy_o <= 1'b0;  // Display-on acknowledged and released
        end else begin
          req_o <= 1'b1;
        end
      end
    end
  end

endmodule

/* design/lcd_host_ctrl.sv */
`timescale 1ns/1ps

module lcd_host_ctrl (
  input  logic                       clk_i,
  input  logic                       flag_rst,
  input  lcd_cmd_pkg::lcd_host_req_t host_i,
  input  logic                       enb_i,
  output logic                       rdy_o,
  output logic                       init_start_o,
  input  logic                       init_busy_i,
  input  logic                       init_req_i,
  output logic                       init_ack_o,
  input  lcd_cmd_pkg::lcd_xfer_t     init_xfer_i,
  output logic                       bus_req_o,
  input  logic                       bus_ack_i,
  output lcd_cmd_pkg::lcd_xfer_t     bus_xfer_o
);

  import lcd_timing_pkg::*;
  import lcd_cmd_pkg::*;

  typedef enum logic [1:0] {
    HC_INIT,  // Init sequencer owns the bus
    HC_IDLE,
    HC_REQ,   // Host transfer in flight
    HC_REL    // Waiting for ack to drop
  } hc_state_e;

  hc_state_e state;
  lcd_xfer_t host_xfer;
  logic      accept;

  assign rdy_o        = (state == HC_IDLE);
  assign accept       = rdy_o && enb_i;
  assign init_start_o = accept && (host_i.op == OP_REINIT);

  ////////////////////////////////////////
  // Bus link routing
  ////////////////////////////////////////

  assign bus_req_o  = init_busy_i ? init_req_i : (state == HC_REQ);
  assign bus_xfer_o = init_busy_i ? init_xfer_i : host_xfer;
  assign init_ack_o = init_busy_i && bus_ack_i;

  // Host transfer payload
  always_ff @(posedge clk_i) begin
    if (accept && (host_i.op == OP_WRITE_CHAR)) begin
      host_xfer <= '{strobe: 1'b1, rs: 1'b1, data: host_i.data, post_dly: DLY_42US};
    end else if (accept && (host_i.op == OP_WRITE_INSTR)) begin
      host_xfer <= '{strobe: 1'b1, rs: 1'b0, data: host_i.data, post_dly: DLY_84US};
    end
  end

  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      state <= HC_INIT;
    end else begin
      case (state)
        HC_INIT: begin
          if (!init_busy_i) begin
            state <= HC_IDLE;
          end
        end
        HC_IDLE: begin
          if (accept) begin
            case (host_i.op)
              OP_WRITE_CHAR, OP_WRITE_INSTR: state <= HC_REQ;
              OP_REINIT:                     state <= HC_INIT;
              default:                       state <= HC_IDLE;  // OP_IDLE ignored
            endcase
          end
        end
        HC_REQ: begin
          if (bus_ack_i) begin
            state <= HC_REL;
          end
        end
        default: begin
          if (!bus_ack_i) begin
            state <= HC_IDLE;
          end
        end
      endcase
    end
  end

  // Re-init only from idle, never on top of a running sequence
  assert property (@(posedge clk_i) disable iff (flag_rst)
    init_start_o |-> !init_busy_i)
    else $error("init restarted while busy");

endmodule

/* design/lcd16x2_top.sv */
`timescale 1ns/1ps

module lcd16x2_top (
  input  logic                       clk_i,
  input  logic                       flag_rst,
  input  lcd_cmd_pkg::lcd_host_req_t host_i,
  input  logic                       enb_i,
  output logic                       rdy_o,
  output lcd_cmd_pkg::lcd_bus_t      lcd_o
);

  import lcd_cmd_pkg::*;

  logic      init_start;
  logic      init_busy;
  logic      init_req;
  logic      init_ack;
  lcd_xfer_t init_xfer;
  logic      bus_req;
  logic      bus_ack;
  lcd_xfer_t bus_xfer;

  lcd_host_ctrl u_host_ctrl (
    .clk_i        (clk_i),
    .flag_rst     (flag_rst),
    .host_i       (host_i),
    .enb_i        (enb_i),
    .rdy_o        (rdy_o),
    .init_start_o (init_start),
    .init_busy_i  (init_busy),
    .init_req_i   (init_req),
    .init_ack_o   (init_ack),
    .init_xfer_i  (init_xfer),
    .bus_req_o    (bus_req),
    .bus_ack_i    (bus_ack),
    .bus_xfer_o   (bus_xfer)
  );

  lcd_init_seq u_init_seq (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .start_i  (init_start),
    .busy_o   (init_busy),
    .req_o    (init_req),
    .ack_i    (init_ack),
    .xfer_o   (init_xfer)
  );

  lcd_bus_cycle u_bus_cycle (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .req_i    (bus_req),
    .xfer_i   (bus_xfer),
    .ack_o    (bus_ack),
    .lcd_o    (lcd_o)
  );

endmodule

/* verification/lcd_bus_monitor.sv */
`timescale 1ns/1ps

module lcd_bus_monitor (
  input  logic                  clk_i,
  input  logic                  flag_rst,
  input  logic                  rdy_i,
  input  lcd_cmd_pkg::lcd_bus_t lcd_i,
  output logic                  fail_o
);

  import lcd_timing_pkg::*;
  import lcd_cmd_pkg::*;

  typedef struct packed {
    logic       rs;
    logic [7:0] data;
    delay_cnt_t min_gap;  // Low cycles needed since the previous E fall
  } exp_write_t;

  exp_write_t  exp_q[$];
  lcd_bus_t    lcd_q;
  logic        rdy_q;
  int unsigned hi_cnt;      // Samples with E high
  int unsigned stable_cnt;  // Samples since data last changed
  int unsigned gap_cnt;     // Samples with E low
  logic        failed = 1'b0;

  assign fail_o = failed;

  task automatic expect_write(input logic rs, input logic [7:0] data, input delay_cnt_t min_gap);
    exp_write_t w;
    w.rs      = rs;
    w.data    = data;
    w.min_gap = min_gap;
    exp_q.push_back(w);
  endtask

  function automatic int unsigned pending_writes();
    return exp_q.size();
  endfunction

  ////////////////////////////////////////
  // Checks at E edges
  ////////////////////////////////////////

  task automatic check_rise();
    if (exp_q.size() == 0) begin
      $display("E strobe on the LCD bus while no write was expected");
      failed = 1'b1;
    end else begin
      assert (gap_cnt >= exp_q[0].min_gap) else begin
        $display("E rose %0d cycles after the previous write, %0d required",
                 gap_cnt, exp_q[0].min_gap);
        failed = 1'b1;
      end
    end
  endtask

  task automatic check_fall();
    exp_write_t w;
    if (exp_q.size() != 0) begin
      w = exp_q.pop_front();
      assert (lcd_i.rs == w.rs) else begin
        $display("[FAIL] lcd_o.rs: expected 0x%0h, got 0x%0h", w.rs, lcd_i.rs);
        failed = 1'b1;
      end
      assert (lcd_i.data == w.data) else begin
        $display("[FAIL] lcd_o.data: expected 0x%02h, got 0x%02h", w.data, lcd_i.data);
        failed = 1'b1;
      end
      assert (hi_cnt >= T_40NS_CYC + T_250NS_CYC) else begin
        $display("E pulse lasted only %0d cycles", hi_cnt);
        failed = 1'b1;
      end
      assert (stable_cnt >= T_250NS_CYC) else begin
        $display("Data changed %0d cycles before E fell", stable_cnt);
        failed = 1'b1;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (flag_rst) begin
      lcd_q      <= '0;
      rdy_q      <= 1'b0;
      hi_cnt     <= 0;
      stable_cnt <= 0;
      gap_cnt    <= 0;
    end else begin
      assert (!(lcd_i.e && rdy_i)) else begin
        $display("[FAIL] rdy_o: expected 0x0 while E is high, got 0x%0h", rdy_i);
        failed = 1'b1;
      end
      if (lcd_i.e && !lcd_q.e) check_rise();
      if (!lcd_i.e && lcd_q.e) check_fall();
      // Ready may only return once every queued write has been seen
      assert (!(rdy_i && !rdy_q) || exp_q.size() == 0) else begin
        $display("rdy_o rose with %0d expected LCD writes still missing", exp_q.size());
        failed = 1'b1;
      end
      hi_cnt     <= lcd_i.e ? hi_cnt + 1 : 0;
      stable_cnt <= (lcd_i.data != lcd_q.data) ? 1 : stable_cnt + 1;
      gap_cnt    <= lcd_i.e ? 0 : gap_cnt + 1;
      lcd_q      <= lcd_i;
      rdy_q      <= rdy_i;
    end
  end

endmodule

/* verification/tb_lcd16x2.sv */
`timescale 1ns/1ps

module tb_lcd16x2;

  import lcd_timing_pkg::*;
  import lcd_cmd_pkg::*;

  localparam int unsigned CYCLE_LIMIT = 300_000;  // Two inits plus the writes

  logic          clk_i;
  logic          flag_rst;
  lcd_host_req_t host_i;
  logic          enb_i;
  logic          rdy_o;
  lcd_bus_t      lcd_o;
  logic          mon_fail;
  int unsigned   cycle_cnt = 0;
  integer        seed;
  delay_cnt_t    last_post;  // Settle time of the most recent transfer

  lcd16x2_top u_dut (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .host_i   (host_i),
    .enb_i    (enb_i),
    .rdy_o    (rdy_o),
    .lcd_o    (lcd_o)
  );

  lcd_bus_monitor u_mon (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .rdy_i    (rdy_o),
    .lcd_i    (lcd_o),
    .fail_o   (mon_fail)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("Regression failed");
    $fatal(1, "%s", reason);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) abort_run("Timeout, the run exceeded its cycle limit");
  end

  always @(posedge mon_fail) abort_run("The LCD bus monitor reported an error");

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Power-on list as it should appear after the 100 ms wait
  task automatic queue_init_list();
    logic [7:0]  cmd_list  [0:INIT_STEPS-1];
    int unsigned post_list [0:INIT_STEPS-1];
    cmd_list  = '{CMD_FUNC_WAKE, CMD_FUNC_WAKE, CMD_FUNC_WAKE, CMD_SETUP,
                  CMD_DISP_OFF, CMD_CLEAR, CMD_ENTRY_N, CMD_DISP_ON};
    post_list = '{T_5MS_CYC, T_100US_CYC, T_100US_CYC, T_100US_CYC,
                  T_60US_CYC, T_5MS_CYC, T_60US_CYC, T_60US_CYC};
    last_post = delay_cnt_t'(T_100MS_CYC);
    for (int i = 0; i < INIT_STEPS; i++) begin
      u_mon.expect_write(1'b0, cmd_list[i], last_post);
      last_post = delay_cnt_t'(post_list[i]);
    end
  endtask

  task automatic send_request(input lcd_op_e op, input logic [7:0] data);
    @(posedge clk_i);
    host_i <= '{op: op, data: data};
    enb_i  <= 1'b1;
    @(posedge clk_i);
    enb_i  <= 1'b0;
  endtask

  task automatic wait_ready();
    @(posedge clk_i);
    while (!rdy_o) begin
      @(posedge clk_i);
    end
  endtask

  // Requests while rdy_o is low must vanish
  task automatic poke_while_busy(input int unsigned cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      host_i <= '{op: OP_WRITE_CHAR, data: 8'h55};
      enb_i  <= 1'b1;
    end
    @(posedge clk_i);
    enb_i <= 1'b0;
  endtask

  task automatic host_write(input logic rs, input logic [7:0] data, input bit stray);
    send_request(rs ? OP_WRITE_CHAR : OP_WRITE_INSTR, data);
    // The strobe is still cycles away once the request is taken
    u_mon.expect_write(rs, data, last_post);
    if (rs) begin
      last_post = delay_cnt_t'(T_42US_CYC);
    end else begin
      last_post = delay_cnt_t'((84 * CLK_FREQ_HZ + 999_999) / 1_000_000);  // 84 us
    end
    if (stray) poke_while_busy(10);
    wait_ready();
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [7:0] ch;
    seed     = 32'h72a1_f3e9;
    flag_rst = 1'b1;
    enb_i    = 1'b0;
    host_i   = '{op: OP_IDLE, data: 8'h00};
    queue_init_list();
    repeat (16) @(posedge clk_i);
    flag_rst <= 1'b0;
    poke_while_busy(20);
    wait_ready();

    for (int i = 0; i < 4; i++) begin
      ch = 8'($random(seed));
      host_write(1'b1, ch, i == 0);
    end

    send_request(OP_IDLE, 8'hA5);  // Taken and dropped
    repeat (20) begin
      @(posedge clk_i);
      assert (rdy_o) else begin
        $display("[FAIL] rdy_o: expected 0x1, got 0x%0h", rdy_o);
        abort_run("rdy_o fell after an OP_IDLE request");
      end
    end

    host_write(1'b0, 8'hC0, 1'b1);  // Cursor to line 2
    host_write(1'b0, 8'h0E, 1'b0);
    for (int i = 0; i < 2; i++) begin
      ch = 8'($random(seed));
      host_write(1'b1, ch, 1'b0);
    end

    // Re-init repeats the whole list with the host held off
    send_request(OP_REINIT, 8'h00);
    queue_init_list();
    poke_while_busy(20);
    wait_ready();
    ch = 8'($random(seed));
    host_write(1'b1, ch, 1'b0);

    repeat (10) @(posedge clk_i);
    if (!mon_fail && u_mon.pending_writes() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("Expected LCD writes were missing at the end of the run");
    end
  end

endmodule

/* vlog.f */
design/lcd_timing_pkg.sv
design/lcd_cmd_pkg.sv
design/lcd_delay_timer.sv
design/lcd_bus_cycle.sv
design/lcd_init_seq.sv
design/lcd_host_ctrl.sv
design/lcd16x2_top.sv
verification/lcd_bus_monitor.sv
verification/tb_lcd16x2.sv

/* Bender.yml */
package:
  name: lcd16x2

sources:
  - files:
      - design/lcd_timing_pkg.sv
      - design/lcd_cmd_pkg.sv
      - design/lcd_delay_timer.sv
      - design/lcd_bus_cycle.sv
      - design/lcd_init_seq.sv
      - design/lcd_host_ctrl.sv
      - design/lcd16x2_top.sv
  - target: test
    files:
      - verification/lcd_bus_monitor.sv
      - verification/tb_lcd16x2.sv
